//--- common/rf_ecc_macros.svh
// Register file geometry and code word widths
// Check value stored for zero data after reset

`ifndef RF_ECC_MACROS_SVH
`define RF_ECC_MACROS_SVH

// Architectural register count, x0 included
`define RF_NUM_REGS 32

// Data bits per register
`define RF_DATA_W 32

// Check bits per register, enough for distinct columns of weight two or more
`define RF_CHECK_W 6

// Register address width
`define RF_ADDR_W 5

// Check bits of zero data, so a cleared word is never all zeros
`define RF_CHECK_RESET 6'h2A

`endif

//--- common/rf_ecc_pkg.sv
// Code types for the protected register file
// Column rule of the parity matrix and the check bit function

`default_nettype none

`include "rf_ecc_macros.svh"

package rf_ecc_pkg;

  typedef logic [`RF_DATA_W-1:0]  rf_data_t;
  typedef logic [`RF_CHECK_W-1:0] rf_check_t;
  typedef logic [`RF_ADDR_W-1:0]  rf_addr_t;

  // Stored word, check bits above the data as in the core's register array
  typedef struct packed {
    rf_check_t check;
    rf_data_t  data;
  } rf_code_word_t;

  // Column of data bit idx: the idx-th smallest 6-bit value with two or more bits set.
  // Weight-one values are left out so a data flip never aliases a check bit flip
  function automatic rf_check_t rf_ecc_column(int unsigned idx);
    int unsigned rank;
    rf_check_t   col;
    rank = 0;
    col  = '0;
    for (int unsigned v = 0; v < 2 ** `RF_CHECK_W; v++) begin
      if ($countones(rf_check_t'(v)) >= 2) begin
        if (rank == idx) begin
          col = rf_check_t'(v);
        end
        rank++;
      end
    end
    return col;
  endfunction

  // XOR of the columns of all set data bits, offset by the reset check value
  function automatic rf_check_t rf_ecc_check(rf_data_t data);
    rf_check_t check;
    check = `RF_CHECK_RESET;
    for (int unsigned i = 0; i < `RF_DATA_W; i++) begin
      if (data[i]) begin
        check = check ^ rf_ecc_column(i);
      end
    end
    return check;
  endfunction

endpackage

`default_nettype wire

//--- common/rf_port_pkg.sv
// Port structs of the protected register file
// Write strobe, source read addresses and fault injection

`default_nettype none

package rf_port_pkg;

  // Single-cycle write, ignored for x0
  typedef struct packed {
    logic                 we;
    rf_ecc_pkg::rf_addr_t addr;
    rf_ecc_pkg::rf_data_t data;
  } rf_wr_t;

  // Source operand addresses, held as levels
  typedef struct packed {
    rf_ecc_pkg::rf_addr_t rs1;
    rf_ecc_pkg::rf_addr_t rs2;
  } rf_rd_t;

  // Glitch model: mask is XORed into the stored word at addr on the clock edge
  typedef struct packed {
    logic                      en;
    rf_ecc_pkg::rf_addr_t      addr;
    rf_ecc_pkg::rf_code_word_t mask;
  } rf_fault_t;

endpackage

`default_nettype wire

//--- regfile/rf_ecc_encoder.sv
// Write path check bit encoder
// Parity matrix rows derived from the package column rule

`default_nettype none

`include "rf_ecc_macros.svh"

module rf_ecc_encoder (
  input  wire rf_ecc_pkg::rf_data_t data,
  output rf_ecc_pkg::rf_check_t     check
);

  import rf_ecc_pkg::*;

  localparam rf_check_t CHECK_RESET = `RF_CHECK_RESET;

  // Row j of the parity matrix selects the data bits whose column has bit j set
  function automatic rf_data_t row_mask(int unsigned j);
    rf_data_t  mask;
    rf_check_t col;
    mask = '0;
    for (int unsigned i = 0; i < `RF_DATA_W; i++) begin
      col     = rf_ecc_column(i);
      mask[i] = col[j];
    end
    return mask;
  endfunction

  // One parity tree per check bit, the masks are constants after elaboration
  for (genvar j = 0; j < `RF_CHECK_W; j++) begin : g_row
    localparam rf_data_t ROW = row_mask(j);

    assign check[j] = (^(data & ROW)) ^ CHECK_RESET[j];
  end

endmodule

`default_nettype wire

//--- regfile/rf_ecc_storage.sv
// Code word storage for registers x1 to x31
// Write and fault update, combinational source reads with x0 tied to a valid zero word

`default_nettype none

`include "rf_ecc_macros.svh"

module rf_ecc_storage (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire rf_port_pkg::rf_wr_t    wr,
  input  wire rf_ecc_pkg::rf_check_t  wr_check,
  input  wire rf_port_pkg::rf_fault_t fault,
  input  wire rf_port_pkg::rf_rd_t    rd,
  output rf_ecc_pkg::rf_code_word_t   rs1_word,
  output rf_ecc_pkg::rf_code_word_t   rs2_word
);

  import rf_ecc_pkg::*;

  localparam rf_code_word_t ZERO_WORD = '{check: `RF_CHECK_RESET, data: '0};

  rf_code_word_t mem      [1:`RF_NUM_REGS-1];
  rf_code_word_t mem_next [1:`RF_NUM_REGS-1];

  // Next value per register. A fault lands on top of a write in the same cycle,
  // as a glitch on the array would
  always_comb begin
    for (int r = 1; r < `RF_NUM_REGS; r++) begin
      mem_next[r] = mem[r];
      if (wr.we && (wr.addr == rf_addr_t'(r))) begin
        mem_next[r] = '{check: wr_check, data: wr.data};
      end
      if (fault.en && (fault.addr == rf_addr_t'(r))) begin
        mem_next[r] = mem_next[r] ^ fault.mask;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int r = 1; r < `RF_NUM_REGS; r++) begin
        mem[r] <= ZERO_WORD;
      end
    end else begin
      for (int r = 1; r < `RF_NUM_REGS; r++) begin
        mem[r] <= mem_next[r];
      end
    end
  end

  // x0 has no storage and reads as a correctly coded zero
  always_comb begin
    rs1_word = ZERO_WORD;
    rs2_word = ZERO_WORD;
    for (int r = 1; r < `RF_NUM_REGS; r++) begin
      if (rd.rs1 == rf_addr_t'(r)) begin
        rs1_word = mem[r];
      end
      if (rd.rs2 == rf_addr_t'(r)) begin
        rs2_word = mem[r];
      end
    end
  end

endmodule

`default_nettype wire

//--- regfile/rf_ecc_checker.sv
// Integrity checker for the two source code words
// Syndrome and stuck word detection, registered major alert

`default_nettype none

module rf_ecc_checker (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire rf_ecc_pkg::rf_code_word_t rs1_word,
  input  wire rf_ecc_pkg::rf_code_word_t rs2_word,
  output logic                           alert_major
);

  import rf_ecc_pkg::*;

  rf_check_t rs1_syndrome;
  rf_check_t rs2_syndrome;
  logic      rs1_faulty;
  logic      rs2_faulty;

  // A word stuck at all zeros or all ones points at a wiped or shorted array,
  // which the syndrome alone may not catch
  function automatic logic word_stuck(rf_code_word_t word);
    return (word == '0) || (&word);
  endfunction

  // Every 1-bit and 2-bit flip gives a nonzero syndrome since the
  // columns are distinct and none has weight one
  assign rs1_syndrome = rf_ecc_check(rs1_word.data) ^ rs1_word.check;
  assign rs2_syndrome = rf_ecc_check(rs2_word.data) ^ rs2_word.check;

  assign rs1_faulty = (rs1_syndrome != '0) || word_stuck(rs1_word);
  assign rs2_faulty = (rs2_syndrome != '0) || word_stuck(rs2_word);

  // Level alert, follows the read faults with one cycle of delay
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      alert_major <= 1'b0;
    end else begin
      alert_major <= rs1_faulty | rs2_faulty;
    end
  end

endmodule

`default_nettype wire

//--- hdl/rf_secure_top.sv
// Protected register file top level
// Encoder on the write path, code word storage and integrity checker

`default_nettype none

module rf_secure_top (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire rf_port_pkg::rf_wr_t    wr,
  input  wire rf_port_pkg::rf_rd_t    rd,
  input  wire rf_port_pkg::rf_fault_t fault,
  output rf_ecc_pkg::rf_data_t        rs1_data,
  output rf_ecc_pkg::rf_data_t        rs2_data,
  output logic                        alert_major
);

  import rf_ecc_pkg::*;

  rf_check_t     wr_check;
  rf_code_word_t rs1_word;
  rf_code_word_t rs2_word;

  rf_ecc_encoder u_encoder (
    .data  (wr.data),
    .check (wr_check)
  );

  rf_ecc_storage u_storage (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wr       (wr),
    .wr_check (wr_check),
    .fault    (fault),
    .rd       (rd),
    .rs1_word (rs1_word),
    .rs2_word (rs2_word)
  );

  rf_ecc_checker u_checker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rs1_word    (rs1_word),
    .rs2_word    (rs2_word),
    .alert_major (alert_major)
  );

  // Operands leave uncorrected, the alert is the only reaction to a fault
  assign rs1_data = rs1_word.data;
  assign rs2_data = rs2_word.data;

endmodule

`default_nettype wire

//--- bench/tb_rf_secure_tasks.svh
// Reference code columns and check bits, driver tasks, compare tasks
// and the directed tests of the protected register file

// Columns are the 6-bit values of weight two or more, in ascending order
task automatic fill_columns();
  int unsigned rank;
  int unsigned ones;
  rank = 0;
  for (int v = 0; v < 2 ** `RF_CHECK_W; v++) begin
    ones = 0;
    for (int b = 0; b < `RF_CHECK_W; b++) begin
      if (v[b]) ones++;
    end
    if ((ones >= 2) && (rank < `RF_DATA_W)) begin
      column_table[rank] = rf_check_t'(v);
      rank++;
    end
  end
endtask

function automatic rf_check_t expected_check(rf_data_t d);
  rf_check_t c;
  c = `RF_CHECK_RESET;
  for (int i = 0; i < `RF_DATA_W; i++) begin
    if (d[i]) c = c ^ column_table[i];
  end
  return c;
endfunction

task automatic check_data(input rf_data_t got, input rf_data_t exp, input string what);
  if (got !== exp) begin
    data_errors++;
    $display("FAIL %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
  end
endtask

task automatic check_alert(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    alert_errors++;
    $display("FAIL %0t: alert_major after %s is %b, expected %b", $time, what, got, exp);
  end
endtask

task automatic write_reg(input rf_addr_t a, input rf_data_t d);
  wr = '{we: 1'b1, addr: a, data: d};
  @(negedge clk_i);
  wr.we = 1'b0;
  if (a != '0) shadow_data[a] = d;
endtask

task automatic inject_fault(input rf_addr_t a, input rf_code_word_t mask);
  fault = '{en: 1'b1, addr: a, mask: mask};
  @(negedge clk_i);
  fault.en = 1'b0;
  if (a != '0) shadow_data[a] = shadow_data[a] ^ mask.data;
endtask

// Data is checked in the read cycle, the alert one cycle later
task automatic read_pair(input rf_addr_t a, input rf_addr_t b, input logic exp_alert);
  string what;
  what  = $sformatf("read of x%0d and x%0d", a, b);
  rd.rs1 = a;
  rd.rs2 = b;
  @(posedge clk_i);
  check_data(rs1_data, shadow_data[a], $sformatf("rs1 x%0d", a));
  check_data(rs2_data, shadow_data[b], $sformatf("rs2 x%0d", b));
  @(negedge clk_i);
  check_alert(alert_major, exp_alert, what);
endtask

task automatic reset_reads();
  for (int a = 0; a < `RF_NUM_REGS; a++) begin
    read_pair(rf_addr_t'(a), rf_addr_t'(`RF_NUM_REGS - 1 - a), 1'b0);
  end
endtask

task automatic random_write_reads();
  for (int n = 0; n < RAND_WRITES; n++) begin
    write_reg(rf_addr_t'(1 + $urandom % 31), rf_data_t'($urandom()));
  end
  write_reg('0, rf_data_t'($urandom()));
  for (int a = 0; a < `RF_NUM_REGS; a++) begin
    read_pair(rf_addr_t'(a), rf_addr_t'(`RF_NUM_REGS - 1 - a), 1'b0);
  end
endtask

// Faulty word seen on rs1, then on rs2, each followed by a clean read
task automatic fault_round(input int unsigned flips);
  rf_addr_t                          r;
  rf_addr_t                          other;
  logic [`RF_CHECK_W+`RF_DATA_W-1:0] bits;
  int unsigned                       b1;
  int unsigned                       b2;
  r     = rf_addr_t'(1 + $urandom % 31);
  other = rf_addr_t'((r % 31) + 1);
  bits  = '0;
  b1    = $urandom % (`RF_CHECK_W + `RF_DATA_W);
  b2    = (b1 + 1 + $urandom % (`RF_CHECK_W + `RF_DATA_W - 1)) % (`RF_CHECK_W + `RF_DATA_W);
  bits[b1] = 1'b1;
  if (flips == 2) bits[b2] = 1'b1;
  inject_fault(r, rf_code_word_t'(bits));
  read_pair(r, '0, 1'b1);
  read_pair(other, other, 1'b0);
  read_pair(other, r, 1'b1);
  read_pair('0, other, 1'b0);
  write_reg(r, rf_data_t'($urandom()));
endtask

task automatic single_bit_faults();
  repeat (FAULT_ROUNDS) fault_round(1);
endtask

task automatic double_bit_faults();
  repeat (FAULT_ROUNDS) fault_round(2);
endtask

task automatic stuck_word_faults();
  rf_addr_t      r;
  rf_code_word_t mask;
  r         = rf_addr_t'(1 + $urandom % 31);
  // Zero data carries the reset check value, clearing it wipes the word
  write_reg(r, '0);
  mask.data  = '0;
  mask.check = `RF_CHECK_RESET;
  inject_fault(r, mask);
  read_pair(r, r, 1'b1);
  write_reg(r, '1);
  mask.check = expected_check('1) ^ {`RF_CHECK_W{1'b1}};
  inject_fault(r, mask);
  read_pair('0, r, 1'b1);
  write_reg(r, rf_data_t'($urandom()));
  read_pair(r, r, 1'b0);
endtask

task automatic x0_fault_ignored();
  rf_code_word_t mask;
  mask = '{check: rf_check_t'($urandom()) | 6'h01, data: rf_data_t'($urandom())};
  inject_fault('0, mask);
  read_pair('0, '0, 1'b0);
endtask

//--- bench/tb_rf_secure.sv
// Testbench for the protected register file
// Clock, reset, DUT instance, watchdog and the order of the directed tests

`default_nettype none

`include "rf_ecc_macros.svh"

module tb_rf_secure;

  import rf_ecc_pkg::*;
  import rf_port_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 10;
  localparam int RAND_WRITES  = 40;
  localparam int FAULT_ROUNDS = 4;
  localparam int ROUND_CYCLES = 6;
  localparam int STUCK_CYCLES = 8;
  localparam int X0_CYCLES    = 2;
  localparam int unsigned SEED = 32'hc509_ec6b;

  // Every read, write or injected fault takes one cycle
  localparam int TEST_CYCLES = RESET_CYCLES + `RF_NUM_REGS
                             + RAND_WRITES + 1 + `RF_NUM_REGS
                             + 2 * FAULT_ROUNDS * ROUND_CYCLES
                             + STUCK_CYCLES + X0_CYCLES;

  logic      clk_i;
  logic      rst_ni;
  rf_wr_t    wr;
  rf_rd_t    rd;
  rf_fault_t fault;
  rf_data_t  rs1_data;
  rf_data_t  rs2_data;
  logic      alert_major;

  // Reference state: the data each register should return, and the code columns
  rf_data_t  shadow_data  [`RF_NUM_REGS];
  rf_check_t column_table [`RF_DATA_W];

  int data_errors;
  int alert_errors;

  rf_secure_top dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wr          (wr),
    .rd          (rd),
    .fault       (fault),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .alert_major (alert_major)
  );

  `include "tb_rf_secure_tasks.svh"

  initial begin
    clk_i = 1'b0;
  end

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  initial begin
    #(TEST_CYCLES * CLK_PERIOD * 2);
    $display("Watchdog expired before the tests finished");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    rst_ni       = 1'b0;
    wr           = '0;
    rd           = '0;
    fault        = '0;
    data_errors  = 0;
    alert_errors = 0;
    void'($urandom(SEED));
    fill_columns();
    for (int r = 0; r < `RF_NUM_REGS; r++) begin
      shadow_data[r] = '0;
    end

    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;

    // All tasks start and end right after a falling edge
    reset_reads();
    random_write_reads();
    single_bit_faults();
    double_bit_faults();
    stuck_word_faults();
    x0_fault_ignored();

    $display("Errors: %0d data, %0d alert", data_errors, alert_errors);
    if (data_errors + alert_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+common
+incdir+bench
common/rf_ecc_pkg.sv
common/rf_port_pkg.sv
regfile/rf_ecc_encoder.sv
regfile/rf_ecc_storage.sv
regfile/rf_ecc_checker.sv
hdl/rf_secure_top.sv
bench/tb_rf_secure.sv

//--- Makefile
# Verilator build and run of the protected register file testbench

TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_rf_secure
FILELIST = tb.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))
HEADERS  = $(wildcard common/*.svh bench/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source, a header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
